// ==== tb.f ====
+incdir+test
verilog/cpu_pkg.sv
verilog/fetch_unit.sv
verilog/decode_stage.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/mem_stage.sv
verilog/cpu_top.sv
test/tb_cpu_top.sv

// ==== Bender.yml ====
package:
  name: cpu16_pipeline

sources:
  - verilog/cpu_pkg.sv
  - verilog/fetch_unit.sv
  - verilog/decode_stage.sv
  - verilog/reg_file.sv
  - verilog/alu.sv
  - verilog/mem_stage.sv
  - verilog/cpu_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_cpu_top.sv

// ==== test/tb_programs.svh ====
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// One row per test. Name, program image loaded from address 0,
// then up to four expected {address, value} words checked after the run
localparam int num_tests  = 9;
localparam int prog_len   = 24;
localparam int max_checks = 4;

string test_name [num_tests] = '{
    "ldi_bytes", "add_sub", "logic_ops", "neg_move", "load_add",
    "branch_eq_ne", "branch_lt_gt", "jump_fwd", "count_loop"
};

// Every program ends with a store to 1ff and a jump to itself
logic [data_width-1:0] prog_image [num_tests][prog_len] = '{
    '{16'h6341, 16'h7121, 16'h4201, 16'h7ab2, 16'h6cd2, 16'h4212, 16'h5ff0, 16'h2000,
      16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
      16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
    '{16'h6f01, 16'h63c2, 16'h70f2, 16'hbff1, 16'h4201, 16'hd3d2, 16'h4212, 16'he021,
      16'h4221, 16'he112, 16'h4232, 16'h5ff0, 16'h2000, 16'h0000, 16'h0000, 16'h0000,
      16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
    '{16'h63c1, 16'h75a1, 16'h6f02, 16'h70f2, 16'hf213, 16'he323, 16'h4203, 16'hf214,
      16'he424, 16'h4214, 16'hf215, 16'he525, 16'h4225, 16'he601, 16'h4231, 16'h5ff0,
      16'h2000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
    '{16'h6231, 16'h7011, 16'he701, 16'h4201, 16'hf216, 16'h4216, 16'h6ff7, 16'h7ff7,
      16'ha027, 16'h4227, 16'h5ff0, 16'h2000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
      16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
    '{16'h0141, 16'h0152, 16'he021, 16'h4201, 16'h0143, 16'h0154, 16'h6005, 16'h6006,
      16'h6007, 16'he043, 16'h4213, 16'h5ff0, 16'h2000, 16'h0000, 16'h0000, 16'h0000,
      16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h1357, 16'h2468, 16'h0000, 16'h0000},
    '{16'h6051, 16'h6052, 16'h6073, 16'he821, 16'h8002, 16'ha019, 16'he831, 16'h8002,
      16'ha029, 16'he831, 16'h8802, 16'ha049, 16'he821, 16'h8802, 16'ha089, 16'h4209,
      16'h5ff0, 16'h2000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
    '{16'h6031, 16'h6092, 16'he821, 16'h9002, 16'ha019, 16'he812, 16'h9002, 16'ha029,
      16'he812, 16'h9802, 16'ha049, 16'he821, 16'h9802, 16'ha089, 16'he811, 16'h9002,
      16'ha109, 16'h4209, 16'h5ff0, 16'h2000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
    '{16'h6771, 16'h4201, 16'h2002, 16'h4151, 16'h4211, 16'h5ff0, 16'h2000, 16'h0000,
      16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
      16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'hbeef, 16'h0000, 16'h0000},
    '{16'h6141, 16'he012, 16'hc011, 16'he831, 16'h8ffd, 16'h4202, 16'h4211, 16'h5ff0,
      16'h2000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
      16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000}
};

int exp_count [num_tests] = '{2, 4, 4, 3, 2, 1, 1, 3, 2};

logic [24:0] exp_pair [num_tests][max_checks] = '{
    '{{9'h020, 16'h1234}, {9'h021, 16'habcd}, 25'h0, 25'h0},
    '{{9'h020, 16'h02ef}, {9'h021, 16'h0dff}, {9'h022, 16'h10ee}, {9'h023, 16'hfd11}},
    '{{9'h020, 16'h0a30}, {9'h021, 16'h5ffc}, {9'h022, 16'h55cc}, {9'h023, 16'ha5c3}},
    '{{9'h020, 16'hfedd}, {9'h021, 16'hfedd}, {9'h022, 16'h0001}, 25'h0},
    '{{9'h020, 16'h37bf}, {9'h021, 16'h37bf}, 25'h0, 25'h0},
    '{{9'h020, 16'h000a}, 25'h0, 25'h0, 25'h0},          // Not-taken paths add 2 and 8
    '{{9'h020, 16'h001a}, 25'h0, 25'h0, 25'h0},
    '{{9'h020, 16'h0077}, {9'h015, 16'hbeef}, {9'h021, 16'h0077}, 25'h0},
    '{{9'h020, 16'h00d2}, {9'h021, 16'h0000}, 25'h0, 25'h0}  // Sum of 1 to 20
};

`endif

// ==== test/tb_cpu_top.sv ====
`default_nettype none

module tb_cpu_top
    import cpu_pkg::*;
();

    localparam int mem_words       = 2 ** addr_width;
    localparam int cycles_per_test = 2000;

    logic                  clk          = 1'b0;
    logic                  rst          = 1'b1;
    logic [data_width-1:0] mem_data_out = '0;
    logic                  mem_cplt     = 1'b0;
    logic [addr_width-1:0] mem_addr;
    logic [data_width-1:0] mem_data_in;
    logic                  mem_r_en;
    logic                  mem_w_en;

    logic [data_width-1:0] mem [mem_words];
    logic                  busy     = 1'b0;
    logic [1:0]            wait_cnt = '0;
    logic                  end_seen = 1'b0;    // Store to 1ff completed
    integer                seed     = 32'hc667;
    int                    cur_test = 0;
    int                    errors   = 0;
    int                    checks   = 0;

    `include "tb_programs.svh"

    cpu_top u_cpu_top
    (
        .clk          (clk),
        .rst          (rst),
        .mem_data_out (mem_data_out),
        .mem_cplt     (mem_cplt),
        .mem_addr     (mem_addr),
        .mem_data_in  (mem_data_in),
        .mem_r_en     (mem_r_en),
        .mem_w_en     (mem_w_en)
    );

    always #5 clk = ~clk;

    function automatic logic [data_width-1:0] fill_word(input int addr);
        return data_width'(addr * 37) ^ 16'hc3a5;
    endfunction

    task automatic check_value(input string what, input logic [data_width-1:0] got,
                               input logic [data_width-1:0] expected);
        checks++;
        if (got !== expected)
        begin
            $display("Fail %s: got %h, expected %h", what, got, expected);
            errors++;
        end
    endtask

    // Memory model, image reloaded while reset is high
    always @(posedge clk)
    begin
        if (rst)
        begin
            mem_cplt <= 1'b0;
            busy     <= 1'b0;
            end_seen <= 1'b0;
            for (int a = 0; a < mem_words; a++)
                mem[a] <= (a < prog_len) ? prog_image[cur_test][a] : fill_word(a);
        end
        else if (mem_cplt)
        begin
            mem_cplt <= 1'b0;
            busy     <= 1'b0;
        end
        else if (busy)
        begin
            if (wait_cnt == 2'd0)
            begin
                mem_cplt <= 1'b1;
                if (mem_w_en)
                begin
                    mem[mem_addr] <= mem_data_in;
                    if (mem_addr == 9'h1ff)
                        end_seen <= 1'b1;
                end
                else
                    mem_data_out <= mem[mem_addr];
            end
            else
                wait_cnt <= wait_cnt - 1'b1;
        end
        else if (mem_r_en || mem_w_en)
        begin
            busy     <= 1'b1;
            wait_cnt <= 2'($unsigned($random(seed)) % 3);    // Variable latency
        end
    end

    initial
    begin
        int          errors_before;
        logic [24:0] pair;

        for (int t = 0; t < num_tests; t++)
        begin
            errors_before = errors;
            @(posedge clk);
            cur_test <= t;
            rst      <= 1'b1;
            repeat (8) @(posedge clk);
            rst <= 1'b0;
            while (!end_seen)
                @(posedge clk);
            for (int i = 0; i < exp_count[t]; i++)
            begin
                pair = exp_pair[t][i];
                check_value($sformatf("%s mem[%h]", test_name[t], pair[24:16]),
                            mem[pair[24:16]], pair[15:0]);
            end
            $display("Test %0d %s: %s", t, test_name[t],
                     (errors == errors_before) ? "ok" : "mismatch");
        end

        $display("%0d tests, %0d checks, %0d mismatches", num_tests, checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    // Watchdog
    initial
    begin
        repeat (num_tests * cycles_per_test) @(posedge clk);
        $display("Timeout: a program never reached its final store to address 1ff");
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/cpu_top.sv ====
`default_nettype none

module cpu_top
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [data_width-1:0] mem_data_out,
    input  logic                  mem_cplt,
    output logic [addr_width-1:0] mem_addr,
    output logic [data_width-1:0] mem_data_in,
    output logic                  mem_r_en,
    output logic                  mem_w_en
);

    // Fetch path
    logic                      fetch_req;
    logic [addr_width-1:0]     fetch_addr;
    logic                      fetch_done;
    logic [data_width-1:0]     instr;
    logic                      resolve;
    logic                      taken;
    logic [addr_width-1:0]     target;

    // Stage 0
    logic                      s0_valid;
    logic [data_width-1:0]     s0_instr;
    logic [addr_width-1:0]     s0_pc;
    logic                      s0_take;

    // Register file
    logic [reg_addr_width-1:0] rd_addr_a;
    logic [reg_addr_width-1:0] rd_addr_b;
    logic [data_width-1:0]     rd_data_a;
    logic [data_width-1:0]     rd_data_b;
    logic                      wr_en;
    logic [reg_addr_width-1:0] wr_addr;
    logic [data_width-1:0]     wr_data;

    // Stage 1
    logic                      s1_valid;
    logic [data_width-1:0]     s1_op_a;
    logic [data_width-1:0]     s1_op_b;
    alu_op_e                   s1_alu_op;
    logic [reg_addr_width-1:0] s1_rd;
    logic                      s1_wr_en;
    logic                      s1_mem_rd;
    logic                      s1_mem_wr;
    logic [addr_width-1:0]     s1_addr;
    logic                      s1_jump;
    logic                      s1_branch;
    branch_cond_e              s1_cond;
    logic                      s1_take;

    // Stage 2 and ALU
    logic                      s2_valid;
    logic [reg_addr_width-1:0] s2_rd;
    logic                      s2_wr_en;
    logic [data_width-1:0]     result;
    logic                      equal;
    logic                      less;
    logic                      greater;
    logic                      cmp_en;

    fetch_unit u_fetch_unit (.*);

    decode_stage u_decode_stage (.*);

    reg_file u_reg_file (.*);

    alu u_alu
    (
        .op_a   (s1_op_a),
        .op_b   (s1_op_b),
        .alu_op (s1_alu_op),
        .*
    );

    mem_stage u_mem_stage (.*);

endmodule

`default_nettype wire

// ==== verilog/mem_stage.sv ====
`default_nettype none

module mem_stage
    import cpu_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      s1_valid,
    input  alu_op_e                   s1_alu_op,
    input  logic [reg_addr_width-1:0] s1_rd,
    input  logic                      s1_wr_en,
    input  logic                      s1_mem_rd,
    input  logic                      s1_mem_wr,
    input  logic [addr_width-1:0]     s1_addr,
    input  logic                      s1_jump,
    input  logic                      s1_branch,
    input  branch_cond_e              s1_cond,
    input  logic [data_width-1:0]     result,
    input  logic                      equal,
    input  logic                      less,
    input  logic                      greater,
    input  logic                      fetch_req,
    input  logic [addr_width-1:0]     fetch_addr,
    input  logic [data_width-1:0]     mem_data_out,
    input  logic                      mem_cplt,
    output logic                      s1_take,
    output logic                      cmp_en,
    output logic                      fetch_done,
    output logic [data_width-1:0]     instr,
    output logic                      resolve,
    output logic                      taken,
    output logic [addr_width-1:0]     target,
    output logic                      s2_valid,
    output logic [reg_addr_width-1:0] s2_rd,
    output logic                      s2_wr_en,
    output logic                      wr_en,
    output logic [reg_addr_width-1:0] wr_addr,
    output logic [data_width-1:0]     wr_data,
    output logic [addr_width-1:0]     mem_addr,
    output logic [data_width-1:0]     mem_data_in,
    output logic                      mem_r_en,
    output logic                      mem_w_en
);

    bus_state_e            state;
    logic                  s2_mem_rd;
    logic                  s2_mem_wr;
    logic [addr_width-1:0] s2_addr;
    logic [data_width-1:0] s2_data;
    logic                  s2_mem;
    logic                  retire;
    logic                  cond_met;

    assign s2_mem  = s2_mem_rd || s2_mem_wr;
    assign retire  = s2_valid && (!s2_mem || (state == bus_data && mem_cplt));
    assign s1_take = s1_valid && (!s2_valid || retire);
    assign cmp_en  = s1_take && (s1_alu_op == alu_cmp);

    always_comb
    begin
        case (s1_cond)
            cond_eq: cond_met = equal;
            cond_ne: cond_met = !equal;
            cond_lt: cond_met = less;
            cond_gt: cond_met = greater;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            s2_valid <= 1'b0;
            resolve  <= 1'b0;
            taken    <= 1'b0;
        end
        else
        begin
            // One-cycle pulse as the control instruction lands in stage 2
            resolve <= s1_take && (s1_jump || s1_branch);
            taken   <= s1_take && (s1_jump || (s1_branch && cond_met));
            if (s1_take)
                s2_valid <= 1'b1;
            else if (retire)
                s2_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (s1_take)
        begin
            s2_rd     <= s1_rd;
            s2_wr_en  <= s1_wr_en;
            s2_mem_rd <= s1_mem_rd;
            s2_mem_wr <= s1_mem_wr;
            s2_addr   <= s1_addr;
            s2_data   <= result;
        end
    end

    // Data access wins over fetch, one idle cycle between accesses
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            state <= bus_idle;
        else
        begin
            case (state)
                bus_idle:
                begin
                    if (s2_valid && s2_mem)
                        state <= bus_data;
                    else if (fetch_req)
                        state <= bus_fetch;
                end
                default:
                begin
                    if (mem_cplt)
                        state <= bus_idle;
                end
            endcase
        end
    end

    assign mem_addr    = (state == bus_data) ? s2_addr : fetch_addr;
    assign mem_data_in = s2_data;
    assign mem_r_en    = (state == bus_fetch) || (state == bus_data && s2_mem_rd);
    assign mem_w_en    = (state == bus_data) && s2_mem_wr;

    assign fetch_done = (state == bus_fetch) && mem_cplt;
    assign instr      = mem_data_out;
    assign target     = s2_addr;

    assign wr_en   = retire && s2_wr_en;
    assign wr_addr = s2_rd;
    assign wr_data = s2_mem_rd ? mem_data_out : s2_data;

    // Enables and address hold until completion, then drop for a cycle
    assert property (@(posedge clk) disable iff (rst)
        ((mem_r_en || mem_w_en) && !mem_cplt) |=> $stable({mem_r_en, mem_w_en, mem_addr}))
        else $error("bus request changed before completion");

    assert property (@(posedge clk) disable iff (rst)
        mem_cplt |=> !(mem_r_en || mem_w_en))
        else $error("bus enable still high after completion");

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
`default_nettype none

module alu
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [data_width-1:0] op_a,
    input  logic [data_width-1:0] op_b,
    input  alu_op_e               alu_op,
    input  logic                  cmp_en,
    output logic [data_width-1:0] result,
    output logic                  equal,
    output logic                  less,
    output logic                  greater
);

    always_comb
    begin
        case (alu_op)
            alu_add: result = op_a + op_b;
            alu_sub: result = op_a - op_b;
            alu_and: result = op_a & op_b;
            alu_or:  result = op_a | op_b;
            alu_xor: result = op_a ^ op_b;
            alu_not: result = ~op_a;
            alu_neg: result = -op_a;
            alu_cmp: result = op_a - op_b;    // Not written back
            default: result = '0;
        endcase
    end

    // Flags live until the next compare
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            equal   <= 1'b0;
            less    <= 1'b0;
            greater <= 1'b0;
        end
        else if (cmp_en)
        begin
            equal   <= (op_a == op_b);
            less    <= (op_a < op_b);     // Unsigned
            greater <= (op_a > op_b);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
`default_nettype none

module reg_file
    import cpu_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic [reg_addr_width-1:0] rd_addr_a,
    input  logic [reg_addr_width-1:0] rd_addr_b,
    input  logic                      wr_en,
    input  logic [reg_addr_width-1:0] wr_addr,
    input  logic [data_width-1:0]     wr_data,
    output logic [data_width-1:0]     rd_data_a,
    output logic [data_width-1:0]     rd_data_b
);

    logic [data_width-1:0] regs [num_regs];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            regs <= '{default: '0};
        else if (wr_en)
            regs[wr_addr] <= wr_data;
    end

    // No bypass
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

endmodule

`default_nettype wire

// ==== verilog/decode_stage.sv ====
`default_nettype none

module decode_stage
    import cpu_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      s0_valid,
    input  logic [data_width-1:0]     s0_instr,
    input  logic [addr_width-1:0]     s0_pc,
    input  logic [data_width-1:0]     rd_data_a,
    input  logic [data_width-1:0]     rd_data_b,
    input  logic                      s1_take,
    input  logic                      s2_valid,
    input  logic [reg_addr_width-1:0] s2_rd,
    input  logic                      s2_wr_en,
    output logic                      s0_take,
    output logic [reg_addr_width-1:0] rd_addr_a,
    output logic [reg_addr_width-1:0] rd_addr_b,
    output logic                      s1_valid,
    output logic [data_width-1:0]     s1_op_a,
    output logic [data_width-1:0]     s1_op_b,
    output alu_op_e                   s1_alu_op,
    output logic [reg_addr_width-1:0] s1_rd,
    output logic                      s1_wr_en,
    output logic                      s1_mem_rd,
    output logic                      s1_mem_wr,
    output logic [addr_width-1:0]     s1_addr,
    output logic                      s1_jump,
    output logic                      s1_branch,
    output branch_cond_e              s1_cond
);

    opcode_e               opcode;
    logic [data_width-1:0] op_a_dec;
    logic [data_width-1:0] op_b_dec;
    alu_op_e               alu_op_dec;
    logic [addr_width-1:0] addr_dec;
    logic                  wr_en_dec;
    logic                  mem_rd_dec;
    logic                  mem_wr_dec;
    logic                  jump_dec;
    logic                  branch_dec;
    logic                  use_a;
    logic                  use_b;
    logic                  hit_a;
    logic                  hit_b;
    logic                  hazard;

    assign opcode    = opcode_e'(s0_instr[15:13]);
    assign rd_addr_a = s0_instr[reg_addr_width-1:0];     // Destination, also first source
    assign rd_addr_b = s0_instr[reg_addr_width+3:4];

    always_comb
    begin
        op_a_dec   = '0;
        op_b_dec   = '0;
        alu_op_dec = alu_add;
        addr_dec   = s0_instr[12:4];
        wr_en_dec  = 1'b0;
        mem_rd_dec = 1'b0;
        mem_wr_dec = 1'b0;
        jump_dec   = 1'b0;
        branch_dec = 1'b0;
        use_a      = 1'b0;
        use_b      = 1'b0;

        case (opcode)
            op_load:
            begin
                mem_rd_dec = 1'b1;
                wr_en_dec  = 1'b1;
            end
            op_store:
            begin
                op_a_dec   = rd_data_a;    // Passes through the ALU unchanged
                mem_wr_dec = 1'b1;
                use_a      = 1'b1;
            end
            op_jump:
            begin
                // Offset wraps modulo memory size, low bits suffice
                addr_dec = s0_pc + s0_instr[addr_width-1:0];
                jump_dec = 1'b1;
            end
            op_branch:
            begin
                addr_dec   = s0_pc + s0_instr[addr_width-1:0];
                branch_dec = 1'b1;
            end
            op_load_imm:
            begin
                // Replace one byte, keep the other
                op_a_dec  = s0_instr[12] ? {s0_instr[11:4], rd_data_a[7:0]}
                                         : {rd_data_a[15:8], s0_instr[11:4]};
                wr_en_dec = 1'b1;
                use_a     = 1'b1;
            end
            op_add_imm,
            op_sub_imm:
            begin
                op_a_dec   = rd_data_a;
                op_b_dec   = data_width'(s0_instr[12:4]);
                alu_op_dec = (opcode == op_sub_imm) ? alu_sub : alu_add;
                wr_en_dec  = 1'b1;
                use_a      = 1'b1;
            end
            op_reg:
            begin
                op_a_dec = rd_data_a;
                op_b_dec = rd_data_b;
                if (!s0_instr[12])
                begin
                    case (s0_instr[11:8])
                        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_cmp:
                        begin
                            alu_op_dec = alu_op_e'(s0_instr[11:8]);
                            wr_en_dec  = (s0_instr[11:8] != alu_cmp);
                            use_a      = 1'b1;
                            use_b      = 1'b1;
                        end
                        alu_not, alu_neg:
                        begin
                            alu_op_dec = alu_op_e'(s0_instr[11:8]);
                            wr_en_dec  = 1'b1;
                            use_a      = 1'b1;
                        end
                        default:
                            wr_en_dec = 1'b0;    // Unused code runs as a no-op
                    endcase
                end
                else if (s0_instr[11:8] == reg_move)
                begin
                    op_a_dec  = rd_data_b;
                    op_b_dec  = '0;
                    wr_en_dec = 1'b1;
                    use_b     = 1'b1;
                end
            end
        endcase
    end

    // Read-after-write against writes still in flight
    assign hit_a  = (s1_valid && s1_wr_en && s1_rd == rd_addr_a) ||
                    (s2_valid && s2_wr_en && s2_rd == rd_addr_a);
    assign hit_b  = (s1_valid && s1_wr_en && s1_rd == rd_addr_b) ||
                    (s2_valid && s2_wr_en && s2_rd == rd_addr_b);
    assign hazard = (use_a && hit_a) || (use_b && hit_b);

    assign s0_take = s0_valid && !hazard && (!s1_valid || s1_take);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            s1_valid <= 1'b0;
        else if (s0_take)
            s1_valid <= 1'b1;
        else if (s1_take)
            s1_valid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (s0_take)
        begin
            s1_op_a   <= op_a_dec;
            s1_op_b   <= op_b_dec;
            s1_alu_op <= alu_op_dec;
            s1_rd     <= s0_instr[reg_addr_width-1:0];
            s1_wr_en  <= wr_en_dec;
            s1_mem_rd <= mem_rd_dec;
            s1_mem_wr <= mem_wr_dec;
            s1_addr   <= addr_dec;    // Target for jumps and branches
            s1_jump   <= jump_dec;
            s1_branch <= branch_dec;
            s1_cond   <= branch_cond_e'(s0_instr[12:11]);
        end
    end

    // A stage 1 entry never asks for both bus directions
    assert property (@(posedge clk) disable iff (rst)
        s1_valid |-> !(s1_mem_rd && s1_mem_wr))
        else $error("stage 1 holds a load and a store at once");

endmodule

`default_nettype wire

// ==== verilog/fetch_unit.sv ====
`default_nettype none

module fetch_unit
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  fetch_done,
    input  logic [data_width-1:0] instr,
    input  logic                  s0_take,
    input  logic                  resolve,
    input  logic                  taken,
    input  logic [addr_width-1:0] target,
    output logic                  fetch_req,
    output logic [addr_width-1:0] fetch_addr,
    output logic                  s0_valid,
    output logic [data_width-1:0] s0_instr,
    output logic [addr_width-1:0] s0_pc
);

    logic [addr_width-1:0] pc;
    logic                  ctrl_pend;    // Jump or branch past stage 0, not yet resolved
    logic                  s0_is_ctrl;
    logic                  hold;
    opcode_e               s0_op;

    assign s0_op      = opcode_e'(s0_instr[15:13]);
    assign s0_is_ctrl = (s0_op == op_jump) || (s0_op == op_branch);
    assign hold       = ctrl_pend || (s0_valid && s0_is_ctrl);
    assign fetch_req  = !hold && (!s0_valid || s0_take);
    assign fetch_addr = pc;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            pc        <= '0;
            ctrl_pend <= 1'b0;
            s0_valid  <= 1'b0;
        end
        else
        begin
            // pc already points past the control instruction when not taken
            if (fetch_done)
                pc <= pc + 1'b1;
            else if (resolve && taken)
                pc <= target;

            if (resolve)
                ctrl_pend <= 1'b0;
            else if (s0_take && s0_is_ctrl)
                ctrl_pend <= 1'b1;

            if (fetch_done)
                s0_valid <= 1'b1;
            else if (s0_take)
                s0_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fetch_done)
        begin
            s0_instr <= instr;
            s0_pc    <= pc;    // Own address, base for jump offsets
        end
    end

    // Fetch stays quiet from stage 0 until mem_stage resolves the jump or branch
    assert property (@(posedge clk) disable iff (rst)
        (s0_valid && s0_is_ctrl) |-> (!fetch_req until_with resolve))
        else $error("fetch request while a jump or branch is unresolved");

endmodule

`default_nettype wire

// ==== verilog/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int data_width     = 16;
    localparam int addr_width     = 9;    // Same as the direct-address field
    localparam int reg_addr_width = 4;
    localparam int num_regs       = 16;

    // Register format with bit 12 set
    localparam logic [3:0] reg_move = 4'b0010;

    // Instruction bits 15..13
    typedef enum logic [2:0]
    {
        op_load     = 3'b000,
        op_jump     = 3'b001,
        op_store    = 3'b010,
        op_load_imm = 3'b011,
        op_branch   = 3'b100,
        op_add_imm  = 3'b101,
        op_sub_imm  = 3'b110,
        op_reg      = 3'b111
    } opcode_e;

    // Code 2 unused
    typedef enum logic [3:0]
    {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd3,
        alu_or  = 4'd4,
        alu_xor = 4'd5,
        alu_not = 4'd6,
        alu_neg = 4'd7,
        alu_cmp = 4'd8
    } alu_op_e;

    typedef enum logic [1:0]
    {
        cond_eq,
        cond_ne,
        cond_lt,
        cond_gt
    } branch_cond_e;

    typedef enum logic [1:0]
    {
        bus_idle,
        bus_fetch,
        bus_data
    } bus_state_e;

endpackage

`default_nettype wire
